// File: all.f
+incdir+design
design/rx_pkg.sv
design/cic_fixed.sv
design/cic_var.sv
design/fir_decim.sv
design/rx_decim_chain.sv
verif/rx_decim_chain_asserts.sv
verif/rx_decim_chain_tb.sv

// File: Makefile
TOP := rx_decim_chain_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f all.f \
		--top-module $(TOP) -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then \
		echo "simulation FAILED"; \
		exit 1; \
	fi
	@echo "simulation passed"

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module rx_decim_chain

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: verif/rx_decim_chain_tb.sv
// Testbench for the receive decimation chain; runs constant, rate-change and noise stimulus
`timescale 1ns/100ps
`include "rx_defines.svh"

module rx_decim_chain_tb;

  localparam int PERIOD    = 100;
  // Outputs dropped after each change of stimulus
  localparam int SETTLE    = 50;
  localparam int CHECKED   = 20;
  // Longest quiet time allowed between strobes in clocks
  localparam int STROBE_TO = 1000;
  localparam int NOISE_CLK = 6000;

  logic                        clock;
  logic                        arst_n;
  rx_pkg::rate_e               rate;
  logic signed [`RX_IN_W-1:0]  mix_i;
  logic signed [`RX_IN_W-1:0]  mix_q;
  logic                        out_strobe;
  logic signed [`RX_OUT_W-1:0] out_i;
  logic signed [`RX_OUT_W-1:0] out_q;

  // Expectations written on the falling edge
  bit     check_en;
  longint exp_i;
  longint exp_q;
  int     exp_gap;

  // Comparing process state
  bit first_seen;
  int since_strobe;

  rx_decim_chain dut0 (
    .clock      (clock),
    .arst_n     (arst_n),
    .rate       (rate),
    .mix_i      (mix_i),
    .mix_q      (mix_q),
    .out_strobe (out_strobe),
    .out_i      (out_i),
    .out_q      (out_q)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #(PERIOD/2) clock = ~clock;
    end
  end

  // ----------------------------------------
  // Reference model and helpers
  // ----------------------------------------

  // CIC1 keeps floor(x*125/512) while CIC2 is unity and the FIR gives x256
  function automatic longint dc_expect(input longint x);
    longint s1;
    s1 = (x * 125) >>> 9;
    return s1 * 256;
  endfunction

  function automatic int rate_factor(input rx_pkg::rate_e r);
    case (r)
      rx_pkg::RATE_2:  return 2;
      rx_pkg::RATE_4:  return 4;
      rx_pkg::RATE_8:  return 8;
      default:         return 16;
    endcase
  endfunction

  function automatic logic signed [`RX_IN_W-1:0] rand_sample();
    logic [31:0] raw;
    raw = $urandom;
    return raw[`RX_IN_W-1:0];
  endfunction

  // Failed assertions summed over the bound checkers
  function automatic int assert_failures();
    return dut0.fir0.fir_chk.fail_cnt + dut0.cic2_i.cic_chk.fail_cnt
           + dut0.cic2_q.cic_chk.fail_cnt;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "simulation stopped on first failure");
  endtask

  task automatic check_value(input string name,
                             input logic signed [63:0] got,
                             input logic signed [63:0] exp);
    string line;
    if (got !== exp) begin
      line = $sformatf("error at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
      fail_run(line);
    end
  endtask

  // Count n output strobes with a timeout on each
  task automatic wait_strobes(input int n);
    int got;
    int idle;
    got  = 0;
    idle = 0;
    while (got < n) begin
      @(posedge clock);
      if (out_strobe) begin
        got++;
        idle = 0;
      end else begin
        idle++;
        if (idle > STROBE_TO) begin
          fail_run("out_strobe did not arrive within the timeout");
        end
      end
    end
  endtask

  // Hold constants at one rate, settle, then compare a block of outputs
  task automatic run_constant(input rx_pkg::rate_e r,
                              input logic signed [`RX_IN_W-1:0] xi,
                              input logic signed [`RX_IN_W-1:0] xq);
    @(negedge clock);
    check_en = 1'b0;
    rate     = r;
    mix_i    = xi;
    mix_q    = xq;
    exp_i    = dc_expect(xi);
    exp_q    = dc_expect(xq);
    exp_gap  = 10 * rate_factor(r);
    wait_strobes(SETTLE);
    @(negedge clock);
    check_en = 1'b1;
    wait_strobes(CHECKED);
    @(negedge clock);
    check_en = 1'b0;
  endtask

  // ----------------------------------------
  // Comparing process
  // ----------------------------------------
  always @(posedge clock) begin
    if (!arst_n) begin
      first_seen   = 1'b0;
      since_strobe = 0;
    end else if (out_strobe) begin
      if (check_en) begin
        check_value("out_strobe spacing", since_strobe, exp_gap);
        check_value("out_i", out_i, exp_i);
        check_value("out_q", out_q, exp_q);
      end
      first_seen   = 1'b1;
      since_strobe = 1;
    end else begin
      since_strobe = since_strobe + 1;
      // Outputs stay cleared until the first result
      if (!first_seen) begin
        check_value("out_i", out_i, 0);
        check_value("out_q", out_q, 0);
      end
    end
  end

  // A failed bound assertion ends the run at the next clock
  always @(posedge clock) begin
    if (assert_failures() != 0) begin
      fail_run("a bound assertion on a stage strobe or the FIR sequencer failed");
    end
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin
    rx_pkg::rate_e               order [4];
    rx_pkg::rate_e               tmp;
    int                          j;
    logic signed [`RX_IN_W-1:0]  xi;
    logic signed [`RX_IN_W-1:0]  xq;
    void'($urandom(600));
    arst_n   = 1'b0;
    rate     = rx_pkg::RATE_2;
    mix_i    = '0;
    mix_q    = '0;
    check_en = 1'b0;
    exp_i    = 0;
    exp_q    = 0;
    exp_gap  = 0;
    xi       = '0;
    xq       = '0;
    repeat (4) @(negedge clock);
    arst_n = 1'b1;

    // No strobe while the pipeline fills
    repeat (10) begin
      @(posedge clock);
      check_value("out_strobe", out_strobe, 0);
    end

    // Random order of rates
    order[0] = rx_pkg::RATE_2;
    order[1] = rx_pkg::RATE_4;
    order[2] = rx_pkg::RATE_8;
    order[3] = rx_pkg::RATE_16;
    for (int k = 3; k > 0; k--) begin
      j        = int'($urandom_range(k, 0));
      tmp      = order[k];
      order[k] = order[j];
      order[j] = tmp;
    end

    // Separate constants on I and Q at every rate
    foreach (order[k]) begin
      xi = rand_sample();
      xq = rand_sample();
      run_constant(order[k], xi, xq);
    end

    // Rate change only with the same constants held
    run_constant(order[0], xi, xq);

    // Noise on both channels with one rate change halfway
    for (int n = 0; n < NOISE_CLK; n++) begin
      @(negedge clock);
      mix_i = rand_sample();
      mix_q = rand_sample();
      if (n == NOISE_CLK / 2) begin
        rate = order[1];
      end
    end

    if (assert_failures() != 0) begin
      fail_run("a bound assertion on a stage strobe or the FIR sequencer failed");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

// File: verif/rx_decim_chain_asserts.sv
// Concurrent checks on stage strobes and FIR overrun; bound into cic_var and fir_decim
`timescale 1ns/100ps

module rx_decim_chain_asserts #(
  // Only the FIR has a sequencer that a further pair could overrun
  parameter bit HAS_SEQ = 1'b1
) (
  input logic clock,
  input logic arst_n,
  input logic strobe,
  input logic in_valid,
  input logic busy
);

  // Count of failed assertions in this instance
  int fail_cnt = 0;

  // A stage output is a single-cycle pulse
  strobe_single: assert property (@(posedge clock) disable iff (!arst_n) strobe |=> !strobe)
    else begin
      fail_cnt++;
      $error("stage strobe high on two consecutive cycles");
    end

  // A further pair during the running MAC would overrun the sequencer
  if (HAS_SEQ) begin : g_seq
    no_overrun: assert property (@(posedge clock) disable iff (!arst_n) busy |-> !in_valid)
      else begin
        fail_cnt++;
        $error("input strobe arrived while the FIR still held a pending pair");
      end
  end

  // Strobes held low through reset
  reset_quiet: assert property (@(posedge clock) !arst_n |-> !strobe)
    else begin
      fail_cnt++;
      $error("stage strobe high during reset");
    end

endmodule

bind fir_decim rx_decim_chain_asserts fir_chk (
  .clock    (clock),
  .arst_n   (arst_n),
  .strobe   (out_strobe),
  .in_valid (in_valid),
  .busy     (state == rx_pkg::MAC && phase)
);

bind cic_var rx_decim_chain_asserts #(.HAS_SEQ(1'b0)) cic_chk (
  .clock    (clock),
  .arst_n   (arst_n),
  .strobe   (out_valid),
  .in_valid (in_valid),
  .busy     (1'b0)
);

// File: design/rx_decim_chain.sv
// Top of the receive decimation chain, mixer I/Q in and 24-bit baseband I/Q with a strobe out
`timescale 1ns/100ps
`include "rx_defines.svh"

module rx_decim_chain (
  input  logic                        clock,
  input  logic                        arst_n,
  input  rx_pkg::rate_e               rate,
  input  logic signed [`RX_IN_W-1:0]  mix_i,
  input  logic signed [`RX_IN_W-1:0]  mix_q,
  output logic                        out_strobe,
  output logic signed [`RX_OUT_W-1:0] out_i,
  output logic signed [`RX_OUT_W-1:0] out_q
);

  // Stage 1 to stage 2, I strobe only
  logic                        s1_valid;
  logic signed [`RX_MID_W-1:0] s1_i;
  logic signed [`RX_MID_W-1:0] s1_q;

  // Stage 2 to the FIR
  logic                        s2_valid;
  logic signed [`RX_MID_W-1:0] s2_i;
  logic signed [`RX_MID_W-1:0] s2_q;

  // ----------------------------------------
  // Fixed CIC, decimate by 5
  // ----------------------------------------

  // Mixer samples arrive every clock
  cic_fixed cic1_i (
    .clock     (clock),
    .arst_n    (arst_n),
    .in_valid  (1'b1),
    .in_data   (mix_i),
    .out_valid (s1_valid),
    .out_data  (s1_i)
  );

  // Runs in lockstep with cic1_i
  cic_fixed cic1_q (
    .clock     (clock),
    .arst_n    (arst_n),
    .in_valid  (1'b1),
    .in_data   (mix_q),
    .out_valid (),
    .out_data  (s1_q)
  );

  // ----------------------------------------
  // Variable CIC, decimate by 2 to 16
  // ----------------------------------------
  cic_var cic2_i (
    .clock     (clock),
    .arst_n    (arst_n),
    .rate      (rate),
    .in_valid  (s1_valid),
    .in_data   (s1_i),
    .out_valid (s2_valid),
    .out_data  (s2_i)
  );

  cic_var cic2_q (
    .clock     (clock),
    .arst_n    (arst_n),
    .rate      (rate),
    .in_valid  (s1_valid),
    .in_data   (s1_q),
    .out_valid (),
    .out_data  (s2_q)
  );

  // Final half-band style FIR, decimate by 2
  fir_decim fir0 (
    .clock      (clock),
    .arst_n     (arst_n),
    .in_valid   (s2_valid),
    .in_i       (s2_i),
    .in_q       (s2_q),
    .out_strobe (out_strobe),
    .out_i      (out_i),
    .out_q      (out_q)
  );

endmodule

// File: design/fir_decim.sv
// Dual-channel 8-tap symmetric FIR decimating by 2, one multiplier shared by I and Q
`timescale 1ns/100ps
`include "rx_defines.svh"

module fir_decim (
  input  logic                        clock,
  input  logic                        arst_n,
  input  logic                        in_valid,
  input  logic signed [`RX_MID_W-1:0] in_i,
  input  logic signed [`RX_MID_W-1:0] in_q,
  output logic                        out_strobe,
  output logic signed [`RX_OUT_W-1:0] out_i,
  output logic signed [`RX_OUT_W-1:0] out_q
);

  localparam int TAPS   = `RX_FIR_TAPS;
  localparam int CNT_W  = $clog2(TAPS);
  // Pre-added pair is one bit wider than a sample
  localparam int PRE_W  = `RX_MID_W + 1;
  localparam int PROD_W = PRE_W + 16;
  localparam int ACC_W  = `RX_OUT_W + 10;
  // Q15 sum scaled to input times 256
  localparam int SHIFT  = 7;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TAPS - 1);

  rx_pkg::fir_state_e       state;
  logic                     phase;
  logic         [CNT_W-1:0] cnt;
  logic         [CNT_W-2:0] tap;
  logic                     chan;
  logic signed [`RX_MID_W-1:0] dl_i [TAPS];
  logic signed [`RX_MID_W-1:0] dl_q [TAPS];
  logic signed [`RX_MID_W-1:0] x_near;
  logic signed [`RX_MID_W-1:0] x_far;
  logic signed [PRE_W-1:0]  pre_sum;
  logic signed [15:0]       coef;
  logic signed [PROD_W-1:0] product;
  logic signed [ACC_W-1:0]  product_ext;
  logic signed [ACC_W-1:0]  acc_i;
  logic signed [ACC_W-1:0]  acc_q;
  logic signed [ACC_W-1:0]  q_total;
  logic signed [ACC_W-1:0]  i_scaled;
  logic signed [ACC_W-1:0]  q_scaled;

  // ----------------------------------------
  // Shared multiplier datapath
  // ----------------------------------------

  // Even counts are I, odd counts are Q, upper bits pick the tap pair
  assign tap  = cnt[CNT_W-1:1];
  assign chan = cnt[0];

  always_comb begin
    if (chan) begin
      x_near = dl_q[tap];
      x_far  = dl_q[TAPS - 1 - int'(tap)];
    end else begin
      x_near = dl_i[tap];
      x_far  = dl_i[TAPS - 1 - int'(tap)];
    end
    // Symmetric taps share one product
    pre_sum     = {x_near[`RX_MID_W-1], x_near} + {x_far[`RX_MID_W-1], x_far};
    coef        = rx_pkg::FIR_COEF[tap];
    product     = pre_sum * coef;
    product_ext = {{(ACC_W-PROD_W){product[PROD_W-1]}}, product};
    // Last cycle is a Q product, so fold it in here
    q_total     = acc_q + product_ext;
    i_scaled    = acc_i >>> SHIFT;
    q_scaled    = q_total >>> SHIFT;
  end

  // ----------------------------------------
  // Delay lines and sequencer
  // ----------------------------------------
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state      <= rx_pkg::IDLE;
      phase      <= 1'b0;
      cnt        <= '0;
      acc_i      <= '0;
      acc_q      <= '0;
      out_strobe <= 1'b0;
      out_i      <= '0;
      out_q      <= '0;
      for (int k = 0; k < TAPS; k++) begin
        dl_i[k] <= '0;
        dl_q[k] <= '0;
      end
    end else begin
      out_strobe <= 1'b0;
      // Every pair enters the delay line, newest at index 0
      if (in_valid) begin
        dl_i[0] <= in_i;
        dl_q[0] <= in_q;
        for (int k = 1; k < TAPS; k++) begin
          dl_i[k] <= dl_i[k-1];
          dl_q[k] <= dl_q[k-1];
        end
        phase <= ~phase;
      end
      unique case (state)
        rx_pkg::MAC: begin
          if (chan) begin
            acc_q <= q_total;
          end else begin
            acc_i <= acc_i + product_ext;
          end
          cnt <= cnt + 1'b1;
          if (cnt == CNT_LAST) begin
            out_i      <= i_scaled[`RX_OUT_W-1:0];
            out_q      <= q_scaled[`RX_OUT_W-1:0];
            out_strobe <= 1'b1;
            state      <= rx_pkg::DONE;
          end
        end
        default: begin
          // IDLE and DONE both wait for the second pair of a block
          if (in_valid && phase) begin
            state <= rx_pkg::MAC;
            cnt   <= '0;
            acc_i <= '0;
            acc_q <= '0;
          end else begin
            state <= rx_pkg::IDLE;
          end
        end
      endcase
    end
  end

endmodule

// File: design/cic_var.sv
// Single-channel 5-stage CIC with run-time power-of-two decimation and unity DC gain
`timescale 1ns/100ps
`include "rx_defines.svh"

module cic_var (
  input  logic                        clock,
  input  logic                        arst_n,
  input  rx_pkg::rate_e               rate,
  input  logic                        in_valid,
  input  logic signed [`RX_MID_W-1:0] in_data,
  output logic                        out_valid,
  output logic signed [`RX_MID_W-1:0] out_data
);

  localparam int STAGES = 5;
  localparam int ACC_W  = `RX_CIC2_ACC_W;

  rx_pkg::rate_e           rate_q;
  logic        [3:0]       cnt;
  logic        [3:0]       cnt_last;
  logic        [4:0]       shift;
  logic signed [ACC_W-1:0] in_ext;
  logic signed [ACC_W-1:0] integ [STAGES];
  logic signed [ACC_W-1:0] dly   [STAGES];
  logic signed [ACC_W-1:0] comb  [STAGES];
  logic signed [ACC_W-1:0] scaled;

  // ----------------------------------------
  // Rate decode
  // ----------------------------------------

  // Gain is D^5, so the shift is 5*log2(D)
  always_comb begin
    unique case (rate_q)
      rx_pkg::RATE_2: begin
        cnt_last = 4'd1;
        shift    = 5'd5;
      end
      rx_pkg::RATE_4: begin
        cnt_last = 4'd3;
        shift    = 5'd10;
      end
      rx_pkg::RATE_8: begin
        cnt_last = 4'd7;
        shift    = 5'd15;
      end
      default: begin
        cnt_last = 4'd15;
        shift    = 5'd20;
      end
    endcase
  end

  assign in_ext = {{(ACC_W-`RX_MID_W){in_data[`RX_MID_W-1]}}, in_data};

  // Comb chain and normalizing shift
  always_comb begin
    comb[0] = integ[STAGES-1] - dly[0];
    for (int k = 1; k < STAGES; k++) begin
      comb[k] = comb[k-1] - dly[k];
    end
    scaled = comb[STAGES-1] >>> shift;
  end

  // ----------------------------------------
  // Integrators, combs and decimation count
  // ----------------------------------------
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rate_q    <= rx_pkg::RATE_2;
      cnt       <= '0;
      out_valid <= 1'b0;
      out_data  <= '0;
      for (int k = 0; k < STAGES; k++) begin
        integ[k] <= '0;
        dly[k]   <= '0;
      end
    end else if (rate != rate_q) begin
      // New rate, restart the filter from a clean state
      rate_q    <= rate;
      cnt       <= '0;
      out_valid <= 1'b0;
      for (int k = 0; k < STAGES; k++) begin
        integ[k] <= '0;
        dly[k]   <= '0;
      end
    end else begin
      out_valid <= 1'b0;
      if (in_valid) begin
        integ[0] <= integ[0] + in_ext;
        for (int k = 1; k < STAGES; k++) begin
          integ[k] <= integ[k] + integ[k-1];
        end
        if (cnt == cnt_last) begin
          cnt    <= '0;
          dly[0] <= integ[STAGES-1];
          for (int k = 1; k < STAGES; k++) begin
            dly[k] <= comb[k-1];
          end
          out_data  <= scaled[`RX_MID_W-1:0];
          out_valid <= 1'b1;
        end else begin
          cnt <= cnt + 4'd1;
        end
      end
    end
  end

endmodule

// File: design/cic_fixed.sv
// Single-channel 3-stage CIC decimating by 5; instantiate once per I/Q channel at the chain input
`timescale 1ns/100ps
`include "rx_defines.svh"

module cic_fixed (
  input  logic                        clock,
  input  logic                        arst_n,
  input  logic                        in_valid,
  input  logic signed [`RX_IN_W-1:0]  in_data,
  output logic                        out_valid,
  output logic signed [`RX_MID_W-1:0] out_data
);

  localparam int STAGES = 3;
  localparam int ACC_W  = `RX_CIC1_ACC_W;
  // Drops 9 bits of the 125x CIC gain
  localparam int SHIFT  = 9;
  localparam logic [2:0] CNT_LAST = 3'(`RX_CIC1_R - 1);

  logic        [2:0]       cnt;
  logic signed [ACC_W-1:0] in_ext;
  logic signed [ACC_W-1:0] integ [STAGES];
  logic signed [ACC_W-1:0] dly   [STAGES];
  logic signed [ACC_W-1:0] comb  [STAGES];
  logic signed [ACC_W-1:0] scaled;

  // Sign extend the mixer sample into the accumulator
  assign in_ext = {{(ACC_W-`RX_IN_W){in_data[`RX_IN_W-1]}}, in_data};

  // ----------------------------------------
  // Comb chain on the last integrator
  // ----------------------------------------
  always_comb begin
    comb[0] = integ[STAGES-1] - dly[0];
    for (int k = 1; k < STAGES; k++) begin
      comb[k] = comb[k-1] - dly[k];
    end
    // Arithmetic shift keeps the sign
    scaled = comb[STAGES-1] >>> SHIFT;
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      cnt       <= '0;
      out_valid <= 1'b0;
      out_data  <= '0;
      for (int k = 0; k < STAGES; k++) begin
        integ[k] <= '0;
        dly[k]   <= '0;
      end
    end else begin
      out_valid <= 1'b0;
      if (in_valid) begin
        // Integrators run at the input rate
        integ[0] <= integ[0] + in_ext;
        for (int k = 1; k < STAGES; k++) begin
          integ[k] <= integ[k] + integ[k-1];
        end
        // Every 5th sample updates the combs and the output
        if (cnt == CNT_LAST) begin
          cnt    <= '0;
          dly[0] <= integ[STAGES-1];
          for (int k = 1; k < STAGES; k++) begin
            dly[k] <= comb[k-1];
          end
          out_data  <= scaled[`RX_MID_W-1:0];
          out_valid <= 1'b1;
        end else begin
          cnt <= cnt + 3'd1;
        end
      end
    end
  end

endmodule

// File: design/rx_pkg.sv
// Types and the FIR coefficient table for the receive decimation chain; referenced by scoped name
`include "rx_defines.svh"

package rx_pkg;

  // ----------------------------------------
  // Variable CIC rate code
  // ----------------------------------------

  // Decimation of the second CIC, powers of two only
  typedef enum logic [1:0] {
    RATE_2  = 2'd0,
    RATE_4  = 2'd1,
    RATE_8  = 2'd2,
    RATE_16 = 2'd3
  } rate_e;

  // FIR multiplier sequencer
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    MAC  = 2'd1,
    DONE = 2'd2
  } fir_state_e;

  // ----------------------------------------
  // FIR coefficients, Q15
  // ----------------------------------------

  // Symmetric low-pass, sum is 32768 for unity DC gain
  localparam logic signed [15:0] FIR_COEF [`RX_FIR_TAPS] = '{
    -16'sd512, 16'sd1536, 16'sd4096, 16'sd11264,
    16'sd11264, 16'sd4096, 16'sd1536, -16'sd512
  };

endpackage

// File: design/rx_defines.svh
// Width and size macros shared by the receive decimation chain; include where a width is needed
`ifndef RX_DEFINES_SVH
`define RX_DEFINES_SVH

// ----------------------------------------
// Sample widths at each stage boundary
// ----------------------------------------

// Mixer sample width at the chain input
`define RX_IN_W 18

// Width between CIC1, CIC2 and the FIR
`define RX_MID_W 16

// Baseband output width
`define RX_OUT_W 24

// ----------------------------------------
// Filter sizing
// ----------------------------------------

// Fixed CIC decimation and its accumulator width (18 + 3*log2(5), rounded up)
`define RX_CIC1_R 5
`define RX_CIC1_ACC_W 25

// Variable CIC accumulator, enough for 5 stages at decimation 16
`define RX_CIC2_ACC_W 36

// Number of FIR taps
`define RX_FIR_TAPS 8

`endif
